/* Bender.yml */
package:
  name: matched_filter

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mf_types_pkg.sv
      - rtl/mf_coef_pkg.sv
      - rtl/sample_history.sv
      - rtl/fir_phase_lane.sv
      - rtl/output_saturate.sv
      - rtl/matched_filter_top.sv
  - target: test
    include_dirs:
      - rtl
      - test
    files:
      - test/tb_matched_filter.sv

/* rtl/fir_phase_lane.sv */
`include "mf_params.svh"

// one output phase of the polyphase FIR
// stage 1 is a register of shift-add products, then a balanced
// binary tree of registered adders brings them down to one sum
module fir_phase_lane #(
   parameter int PHASE = 0   // lane index within the block
) (
   input  logic                                      clk_i,
   input  logic                                      reset,
   input  mf_types_pkg::sample_t [`MF_NTAPS-1:0]     taps_window,  // [0] this lane's sample
   output mf_types_pkg::acc_t                        acc
);

   localparam int NTAPS     = `MF_NTAPS;
   localparam int NODES     = NTAPS - 1;       // adders in the tree
   localparam int HEAP      = NODES + NTAPS;   // adders plus product leaves
   localparam int PROD_BITS = `MF_NBITS + 3;   // 4 * min sample needs 3 extra bits

   typedef logic signed [PROD_BITS-1:0] prod_t;

   prod_t              prod   [NTAPS];   // unregistered products
   mf_types_pkg::acc_t tree_q [HEAP];    // [0] root, leaves from NODES upward

   // per-tap constant multiply, built from the table at elaboration
   for (genvar k = 0; k < NTAPS; k++)
   begin : g_tap
      localparam int COEF = int'(mf_coef_pkg::TAPS[k]);
      localparam int MAG  = (COEF < 0) ? -COEF : COEF;

      if (MAG == 0)
      begin : g_zero
         assign prod[k] = '0;   // tap drops out, no logic
      end
      else
      begin : g_mult
         prod_t x_ext;      // sample sign-extended to product width
         prod_t mag_prod;   // |tap| * x

         assign x_ext = taps_window[k];

         case (MAG)
            1:
            begin : g_x1
               assign mag_prod = x_ext;
            end
            2:
            begin : g_x2
               assign mag_prod = x_ext <<< 1;
            end
            3:
            begin : g_x3
               assign mag_prod = (x_ext <<< 1) + x_ext;   // the single adder
            end
            default:
            begin : g_x4
               assign mag_prod = x_ext <<< 2;   // |tap| == 4
            end
         endcase

         // negative taps flip the sign after the shift-add
         if (COEF < 0)
         begin : g_neg
            assign prod[k] = -mag_prod;
         end
         else
         begin : g_pos
            assign prod[k] = mag_prod;
         end
      end
   end

   // heap layout: node i adds children 2i+1 and 2i+2
   // with NTAPS a power of two every leaf sits at the same depth,
   // so each level is exactly one register further from the products
   always_ff @(posedge clk_i)
   begin
      if (reset)
      begin
         for (int i = 0; i < HEAP; i++)
         begin
            tree_q[i] <= '0;
         end
      end
      else
      begin
         for (int k = 0; k < NTAPS; k++)
         begin
            tree_q[NODES + k] <= prod[k];   // sign extends to acc width
         end
         for (int i = 0; i < NODES; i++)
         begin
            // sum of |taps| keeps every partial sum inside acc_t
            tree_q[i] <= tree_q[2*i + 1] + tree_q[2*i + 2];
         end
      end
   end

   assign acc = tree_q[0];   // MF_LANE_STAGES after taps_window

endmodule

/* rtl/matched_filter_top.sv */
`include "mf_params.svh"

// polyphase matched low-pass filter, NSAMPS samples in and out per clock
// free-running, fixed MF_LATENCY from in_i to out_o
module matched_filter_top (
   input  logic                                   clk_i,
   input  logic                                   reset,
   input  mf_types_pkg::sample_t [`MF_NSAMPS-1:0] in_i,    // lane 0 earliest
   output mf_types_pkg::out_t    [`MF_NSAMPS-1:0] out_o,   // same lane order
   output logic                  [`MF_NSAMPS-1:0] clip_o
);

   mf_types_pkg::sample_t [`MF_NTAPS+`MF_NSAMPS-2:0] window;    // newest at [0]
   wire mf_types_pkg::acc_t [`MF_NSAMPS-1:0]         lane_acc;  // one sum per phase

   sample_history u_history (
      .clk_i  (clk_i),
      .reset  (reset),
      .in_i   (in_i),
      .window (window)
   );

   for (genvar p = 0; p < `MF_NSAMPS; p++)
   begin : g_lane
      // lane p's own sample sits NSAMPS-1-p from the newest end
      mf_types_pkg::sample_t [`MF_NTAPS-1:0] lane_window;

      assign lane_window = window[`MF_NSAMPS-1-p +: `MF_NTAPS];

      fir_phase_lane #(
         .PHASE (p)
      ) u_lane (
         .clk_i       (clk_i),
         .reset       (reset),
         .taps_window (lane_window),
         .acc         (lane_acc[p])
      );
   end

   output_saturate u_saturate (
      .clk_i    (clk_i),
      .reset    (reset),
      .lane_acc (lane_acc),
      .out_o    (out_o),
      .clip_o   (clip_o)
   );

endmodule

/* rtl/mf_coef_pkg.sv */
`include "mf_params.svh"

// fixed tap set of the matched low-pass filter
package mf_coef_pkg;

   // small integer coefficient, -4 .. +4 is all the shift-add lane handles
   typedef logic signed [3:0] tap_t;

   // [0] weights the newest sample, [NTAPS-1] the oldest
   localparam tap_t TAPS [`MF_NTAPS] = '{
      0, 2, 3, 4, 4, 4, 4, 4,   // rising edge of the window
      4, 4, 4, 4, 4, 4, 4, 4,   // flat top
      4, 4, 4, 4, 4, 4, 4, 4,
      4, 4, 4, 4, 4, 3, 2, 0    // falling edge, mirror of the start
   };

   // worst-case gain of the filter, bounds the accumulator growth
   function automatic int tap_abs_sum();
      int sum;
      sum = 0;
      for (int k = 0; k < `MF_NTAPS; k++)
      begin
         if (TAPS[k] < 0)
         begin
            sum += -int'(TAPS[k]);
         end
         else
         begin
            sum += int'(TAPS[k]);
         end
      end
      return sum;
   endfunction

   localparam int TAP_ABS_SUM = tap_abs_sum();   // 114 for this table

endpackage

/* rtl/mf_params.svh */
`ifndef MF_PARAMS_SVH
`define MF_PARAMS_SVH

// sample width in bits
`define MF_NBITS 12

// samples per clock, one lane each
`define MF_NSAMPS 4

// filter length, a power of two so the adder tree is balanced
`define MF_NTAPS 32

// growth bits, sum of |taps| is 114 so 7 bits cover it
`define MF_GUARD 7
`define MF_ACC_BITS (`MF_NBITS + `MF_GUARD)

// output word and the scaling ahead of the clip
`define MF_OUT_BITS 12
`define MF_OUT_SHIFT 4

// product register plus five tree levels
`define MF_LANE_STAGES 6

// history + lane + saturate, in clocks
`define MF_LATENCY 8

`endif

/* rtl/mf_types_pkg.sv */
`include "mf_params.svh"

// data types shared by the filter datapath
package mf_types_pkg;

   // one input sample, two's complement
   typedef logic signed [`MF_NBITS-1:0] sample_t;

   // full-precision lane sum, wide enough for the worst case
   // of all samples at full scale with matching tap signs
   typedef logic signed [`MF_ACC_BITS-1:0] acc_t;

   // scaled and clipped result
   typedef logic signed [`MF_OUT_BITS-1:0] out_t;

endpackage

/* rtl/output_saturate.sv */
`include "mf_params.svh"

// divide each lane sum by 2^OUT_SHIFT, clip to the output range
// and register the word and the clip flags
module output_saturate (
   input  logic                                   clk_i,
   input  logic                                   reset,
   input  mf_types_pkg::acc_t [`MF_NSAMPS-1:0]    lane_acc,
   output mf_types_pkg::out_t [`MF_NSAMPS-1:0]    out_o,
   output logic               [`MF_NSAMPS-1:0]    clip_o
);

   localparam int NSAMPS   = `MF_NSAMPS;
   localparam int ACC_BITS = `MF_ACC_BITS;
   localparam int OUT_BITS = `MF_OUT_BITS;
   localparam int HI_BITS  = ACC_BITS - OUT_BITS + 1;   // output sign and all bits above it

   localparam mf_types_pkg::out_t OUT_MAX = {1'b0, {(OUT_BITS-1){1'b1}}};
   localparam mf_types_pkg::out_t OUT_MIN = {1'b1, {(OUT_BITS-1){1'b0}}};

   mf_types_pkg::acc_t    scaled [NSAMPS];   // after the arithmetic shift
   mf_types_pkg::out_t    sat    [NSAMPS];   // clipped value
   logic     [NSAMPS-1:0] clip;

   always_comb
   begin
      for (int p = 0; p < NSAMPS; p++)
      begin
         scaled[p] = lane_acc[p] >>> `MF_OUT_SHIFT;   // floor, no rounding
         // in range only when the upper bits are all copies of the sign
         clip[p] = scaled[p][ACC_BITS-1 -: HI_BITS] != {HI_BITS{scaled[p][ACC_BITS-1]}};
         if (!clip[p])
         begin
            sat[p] = scaled[p][OUT_BITS-1:0];
         end
         else if (scaled[p][ACC_BITS-1])
         begin
            sat[p] = OUT_MIN;   // negative overflow
         end
         else
         begin
            sat[p] = OUT_MAX;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset)
      begin
         out_o  <= '0;
         clip_o <= '0;
      end
      else
      begin
         for (int p = 0; p < NSAMPS; p++)
         begin
            out_o[p] <= sat[p];
         end
         clip_o <= clip;
      end
   end

endmodule

/* rtl/sample_history.sv */
`include "mf_params.svh"

// sliding window of the most recent NTAPS + NSAMPS - 1 samples
// each clock one whole input block is pushed in at the newest end
module sample_history (
   input  logic                                              clk_i,
   input  logic                                              reset,
   input  mf_types_pkg::sample_t [`MF_NSAMPS-1:0]            in_i,   // [0] earliest in time
   output mf_types_pkg::sample_t [`MF_NTAPS+`MF_NSAMPS-2:0]  window  // [0] newest
);

   localparam int NSAMPS = `MF_NSAMPS;
   localparam int DEPTH  = `MF_NTAPS + `MF_NSAMPS - 1;   // oldest lane still needs NTAPS-1 past

   always_ff @(posedge clk_i)
   begin
      if (reset)
      begin
         window <= '0;   // empty history reads as zeros
      end
      else
      begin
         // incoming block, reversed so the latest sample lands at [0]
         for (int j = 0; j < NSAMPS; j++)
         begin
            window[j] <= in_i[NSAMPS-1-j];
         end
         // older samples move back by one block
         // the last NSAMPS entries fall off the end
         for (int j = NSAMPS; j < DEPTH; j++)
         begin
            window[j] <= window[j-NSAMPS];
         end
      end
   end

endmodule

/* tb.f */
+incdir+rtl
+incdir+test
rtl/mf_types_pkg.sv
rtl/mf_coef_pkg.sv
rtl/sample_history.sv
rtl/fir_phase_lane.sv
rtl/output_saturate.sv
rtl/matched_filter_top.sv
test/tb_matched_filter.sv

/* test/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// golden model of the matched filter, included inside the testbench module
// history of single samples, newest at [0], zero before the stream starts
int hist [`MF_NTAPS];

// expected words wait here until they reach the DUT output
logic [`MF_NSAMPS*`MF_OUT_BITS-1:0] exp_out_q [$];
logic [`MF_NSAMPS-1:0]              exp_clip_q [$];

function automatic void model_clear();
   for (int k = 0; k < `MF_NTAPS; k++)
   begin
      hist[k] = 0;
   end
   exp_out_q.delete();
   exp_clip_q.delete();
endfunction

// run one block through the rule, lane 0 first since it is earliest
function automatic void model_push(input logic [`MF_NSAMPS*`MF_NBITS-1:0] blk);
   int acc;
   int scaled;
   int out_max;
   int out_min;
   logic [`MF_NSAMPS*`MF_OUT_BITS-1:0] word;
   logic [`MF_NSAMPS-1:0]              clips;
   out_max = (1 << (`MF_OUT_BITS - 1)) - 1;
   out_min = -(1 << (`MF_OUT_BITS - 1));
   for (int p = 0; p < `MF_NSAMPS; p++)
   begin
      for (int k = `MF_NTAPS - 1; k > 0; k--)
      begin
         hist[k] = hist[k-1];
      end
      hist[0] = $signed(blk[p*`MF_NBITS +: `MF_NBITS]);   // sign extend to int
      acc = 0;
      for (int k = 0; k < `MF_NTAPS; k++)
      begin
         acc += int'(mf_coef_pkg::TAPS[k]) * hist[k];   // x(n-k) weighted by tap k
      end
      scaled   = acc >>> `MF_OUT_SHIFT;   // floor division by 2^shift
      clips[p] = (scaled > out_max) || (scaled < out_min);
      if (scaled > out_max)
      begin
         scaled = out_max;
      end
      else if (scaled < out_min)
      begin
         scaled = out_min;
      end
      word[p*`MF_OUT_BITS +: `MF_OUT_BITS] = scaled[`MF_OUT_BITS-1:0];
   end
   exp_out_q.push_back(word);
   exp_clip_q.push_back(clips);
endfunction

`endif

/* test/tb_matched_filter.sv */
`include "mf_params.svh"

module tb_matched_filter;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 16;
   localparam int DRIVE_DELAY  = 2;    // after the rising edge
   localparam int NSAMPS       = `MF_NSAMPS;
   localparam int NBITS        = `MF_NBITS;
   localparam int OUT_BITS     = `MF_OUT_BITS;
   localparam int NROWS        = 6;

   typedef enum logic [1:0] {KIND_IMPULSE, KIND_CONST, KIND_RANDOM, KIND_EXTREME} kind_e;

   typedef struct packed {
      kind_e kind;
      int    count;      // blocks in this row
      int    value;      // sample value, unused for random rows
      bit    settles;    // row ends on a steady output
      int    exp_out;    // steady output on every lane
      bit    exp_clip;   // steady clip flag on every lane
   } row_t;

   localparam row_t STIM [NROWS] = '{
      '{KIND_IMPULSE, 12, 256, 1'b0, 0, 1'b0},         // single 256 in lane 0, then zeros
      '{KIND_CONST,   16, 64, 1'b1, 456, 1'b0},        // settles to 114*64/16
      '{KIND_EXTREME, 12, 2047, 1'b1, 2047, 1'b1},     // full-scale positive
      '{KIND_EXTREME, 12, -2048, 1'b1, -2048, 1'b1},   // full-scale negative
      '{KIND_CONST,   12, 5, 1'b1, 35, 1'b0},          // small again, clip flags drop
      '{KIND_RANDOM,  200, 0, 1'b0, 0, 1'b0}           // long random stream
   };

   logic                                  clk_i;
   logic                                  reset;
   mf_types_pkg::sample_t [NSAMPS-1:0]    in_i;
   mf_types_pkg::out_t    [NSAMPS-1:0]    out_o;
   logic                  [NSAMPS-1:0]    clip_o;

   int seed = 25506;

   `include "tb_ref_model.svh"

   matched_filter_top u_dut (
      .clk_i  (clk_i),
      .reset  (reset),
      .in_i   (in_i),
      .out_o  (out_o),
      .clip_o (clip_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD/2) clk_i = ~clk_i;
   end

   function automatic int table_blocks();
      int total;
      total = 0;
      for (int r = 0; r < NROWS; r++)
      begin
         total += STIM[r].count;
      end
      return total;
   endfunction

   // first mismatch ends the run
   task automatic check(input logic signed [63:0] actual, input logic signed [63:0] expected,
                        input string msg);
      if (actual !== expected)
      begin
         $display("Mismatch at %0t: %s (got %0d, expected %0d)", $time, msg, actual, expected);
         $display("Some tests failed");
         $fatal(1, "check failed");
      end
   endtask

   // one block for position idx within a table row
   task automatic make_block(input row_t row, input int idx,
                             output logic [NSAMPS*NBITS-1:0] blk);
      blk = '0;
      for (int p = 0; p < NSAMPS; p++)
      begin
         case (row.kind)
            KIND_IMPULSE:
            begin
               if (idx == 0 && p == 0)
               begin
                  blk[p*NBITS +: NBITS] = row.value[NBITS-1:0];
               end
            end
            KIND_RANDOM:
            begin
               blk[p*NBITS +: NBITS] = $random(seed);   // low bits, full sample range
            end
            default:
            begin
               blk[p*NBITS +: NBITS] = row.value[NBITS-1:0];   // held constant or full scale
            end
         endcase
      end
   endtask

   // check the output due this cycle, then drive the next block
   task automatic apply_block(input logic [NSAMPS*NBITS-1:0] blk);
      logic [NSAMPS*OUT_BITS-1:0] exp_word;
      logic [NSAMPS-1:0]          exp_clips;
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (exp_out_q.size() == 0)
      begin
         $display("The expected-value queue ran empty at %0t", $time);
         $display("Some tests failed");
         $fatal(1, "model queue empty");
      end
      exp_word  = exp_out_q.pop_front();
      exp_clips = exp_clip_q.pop_front();
      for (int p = 0; p < NSAMPS; p++)
      begin
         check(out_o[p], $signed(exp_word[p*OUT_BITS +: OUT_BITS]),
               $sformatf("out_o lane %0d", p));
      end
      check(clip_o, exp_clips, "clip_o");
      in_i = blk;
      model_push(blk);   // due on out_o MF_LATENCY cycles from now
   endtask

   initial
   begin
      logic [NSAMPS*NBITS-1:0]    blk;
      logic [NSAMPS*OUT_BITS-1:0] tail_word;    // expected word of a row's last block
      logic [NSAMPS-1:0]          tail_clips;
      reset = 1'b1;
      in_i  = '0;
      model_clear();
      repeat (RESET_CYCLES)
      begin
         @(posedge clk_i);
         #DRIVE_DELAY;
         check(out_o, 0, "out_o during reset");
         check(clip_o, 0, "clip_o during reset");
      end
      reset = 1'b0;
      // pipeline holds only zeros, so the first MF_LATENCY outputs stay 0
      repeat (`MF_LATENCY)
      begin
         model_push('0);
      end
      for (int r = 0; r < NROWS; r++)
      begin
         for (int i = 0; i < STIM[r].count; i++)
         begin
            make_block(STIM[r], i, blk);
            apply_block(blk);
         end
         // last block of a held row sees a full window of the same value
         if (STIM[r].settles)
         begin
            tail_word  = exp_out_q[$];
            tail_clips = exp_clip_q[$];
            for (int p = 0; p < NSAMPS; p++)
            begin
               check($signed(tail_word[p*OUT_BITS +: OUT_BITS]), STIM[r].exp_out,
                     $sformatf("steady output of row %0d lane %0d", r, p));
            end
            check(tail_clips, {NSAMPS{STIM[r].exp_clip}},
                  $sformatf("steady clip flags of row %0d", r));
         end
      end
      repeat (`MF_LATENCY)
      begin
         apply_block('0);   // flush the last real blocks to the output
      end
      $display("All tests passed");
      $finish;
   end

   // run length follows the table size
   initial
   begin
      int limit;
      limit = table_blocks() + `MF_LATENCY + 40;
      #(limit * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Some tests failed");
      $fatal(1, "watchdog expired");
   end

endmodule
